// ==== dp_aux_source.f ====
+incdir+.
dp_aux_pkg.sv
aux_if.sv
aux_request_arbiter.sv
native_message_encoder.sv
aux_line_driver.sv
reply_decoder.sv
dp_aux_source.sv
tb_dp_aux_source.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f dp_aux_source.f \
    --top-module tb_dp_aux_source -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
grep -q "Done: no errors" sim.log

// ==== tb_dp_aux_source.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module tb_dp_aux_source;

    localparam int n_rows      = 8;
    localparam int cycle_limit = 20 * n_rows * (`AUX_REPLY_TIMEOUT + 40);
    localparam int n_fail_req  = `AUX_MAX_RETRY + 1;

    // requester column of the table
    localparam int by_spm  = 0;
    localparam int by_lpm  = 1;
    localparam int by_both = 2;

    localparam logic [1:0] ack_c   = dp_aux_pkg::reply_ack;
    localparam logic [1:0] nack_c  = dp_aux_pkg::reply_nack;
    localparam logic [1:0] defer_c = dp_aux_pkg::reply_defer;

    // up to five request bytes with byte 0 in slot 0
    typedef logic [4:0][`AUX_DATA_W-1:0] req_bytes_t;

    typedef struct packed {
        int                      who;
        logic                    we;
        logic [`AUX_ADDR_W-1:0]  adr;
        logic [`AUX_LEN_W-1:0]   len;
        logic [`AUX_DATA_W-1:0]  dat;
        logic                    silent;
        logic [3:0][1:0]         replies;
        int                      n_req;
        dp_aux_pkg::aux_status_t status;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    spm_cyc;
    logic                    spm_stb;
    logic                    spm_we;
    logic [`AUX_ADDR_W-1:0]  spm_adr;
    logic [`AUX_LEN_W-1:0]   spm_len;
    logic [`AUX_DATA_W-1:0]  spm_dat_w;
    logic                    spm_ack;
    logic                    lpm_cyc;
    logic                    lpm_stb;
    logic                    lpm_we;
    logic [`AUX_ADDR_W-1:0]  lpm_adr;
    logic [`AUX_LEN_W-1:0]   lpm_len;
    logic [`AUX_DATA_W-1:0]  lpm_dat_w;
    logic                    lpm_ack;
    dp_aux_pkg::aux_status_t reply_status;
    logic [`AUX_DATA_W-1:0]  reply_data;
    logic                    reply_data_vld;
    logic [`AUX_DATA_W-1:0]  aux_out;
    logic                    aux_out_en;
    logic [`AUX_DATA_W-1:0]  aux_in;
    logic                    phy_start_stop;

    row_t                   rows [n_rows];
    logic [`AUX_DATA_W-1:0] read_bytes [n_rows][`AUX_MAX_READ];
    req_bytes_t             req_log [$];
    int                     req_n_log [$];
    int                     cur_row;
    int                     row_base;
    int                     cycles = 0;

    dp_aux_source uut (
        .clk            (clk),
        .reset          (reset),
        .spm_cyc        (spm_cyc),
        .spm_stb        (spm_stb),
        .spm_we         (spm_we),
        .spm_adr        (spm_adr),
        .spm_len        (spm_len),
        .spm_dat_w      (spm_dat_w),
        .spm_ack        (spm_ack),
        .lpm_cyc        (lpm_cyc),
        .lpm_stb        (lpm_stb),
        .lpm_we         (lpm_we),
        .lpm_adr        (lpm_adr),
        .lpm_len        (lpm_len),
        .lpm_dat_w      (lpm_dat_w),
        .lpm_ack        (lpm_ack),
        .reply_status   (reply_status),
        .reply_data     (reply_data),
        .reply_data_vld (reply_data_vld),
        .aux_out        (aux_out),
        .aux_out_en     (aux_out_en),
        .aux_in         (aux_in),
        .phy_start_stop (phy_start_stop)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "cycle limit reached");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure report and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_status(input dp_aux_pkg::aux_status_t got,
                                input dp_aux_pkg::aux_status_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("Fail %0t: %s status %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_byte(input logic [`AUX_DATA_W-1:0] got,
                              input logic [`AUX_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_request(input req_bytes_t got, input int got_n,
                                 input req_bytes_t exp, input int exp_n, input int attempt);
        if (got_n != exp_n) begin
            stop_run($sformatf("Fail %0t: request %0d has %0d bytes, expected %0d",
                               $time, attempt, got_n, exp_n));
        end
        for (int i = 0; i < exp_n; i++) begin
            check_byte(got[i], exp[i], $sformatf("request %0d byte %0d", attempt, i));
        end
    endtask

    // native header is cmd with adr 19:16, adr 15:8, adr 7:0 and len - 1, then write data
    function automatic req_bytes_t expected_request(input row_t r);
        req_bytes_t           b;
        dp_aux_pkg::aux_cmd_t cmd;
        cmd  = r.we ? dp_aux_pkg::cmd_write : dp_aux_pkg::cmd_read;
        b    = '0;
        b[0] = {cmd, r.adr[`AUX_ADDR_W-1:16]};
        b[1] = r.adr[15:8];
        b[2] = r.adr[7:0];
        b[3] = r.len - 1'b1;
        if (r.we) begin
            b[4] = r.dat;
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // sink model
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_reply(input logic [1:0] code, input int r);
        int n_data;
        n_data = 0;
        // only an ack to a read carries data
        if (code == ack_c && !rows[r].we) begin
            n_data = int'(rows[r].len);
        end
        repeat (2) @(posedge clk);
        phy_start_stop <= 1'b1;
        aux_in         <= {2'b00, code, 4'b0000};
        for (int i = 0; i < n_data; i++) begin
            @(posedge clk);
            aux_in <= read_bytes[r][i];
        end
        @(posedge clk);
        phy_start_stop <= 1'b0;
        aux_in         <= '0;
    endtask

    initial begin : sink_model
        req_bytes_t cur;
        int         n;
        int         k;
        aux_in         = '0;
        phy_start_stop = 1'b0;
        cur            = '0;
        n              = 0;
        forever begin
            @(negedge clk);
            if (aux_out_en) begin
                if (n < 5) begin
                    cur[n] = aux_out;
                end
                n = n + 1;
            end else if (n != 0) begin
                // request over so log it and answer for this attempt
                req_log.push_back(cur);
                req_n_log.push_back(n);
                k   = req_log.size() - 1 - row_base;
                cur = '0;
                n   = 0;
                if (k > 3) begin
                    k = 3;
                end
                if (!rows[cur_row].silent) begin
                    send_reply(rows[cur_row].replies[k], cur_row);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_row(input int idx, input int who, input logic we, input int len,
                           input logic silent, input logic [3:0][1:0] replies,
                           input int n_req, input dp_aux_pkg::aux_status_t status);
        rows[idx].who     = who;
        rows[idx].we      = we;
        rows[idx].adr     = `AUX_ADDR_W'($urandom);
        rows[idx].len     = `AUX_LEN_W'(len);
        rows[idx].dat     = `AUX_DATA_W'($urandom);
        rows[idx].silent  = silent;
        rows[idx].replies = replies;
        rows[idx].n_req   = n_req;
        rows[idx].status  = status;
        for (int i = 0; i < `AUX_MAX_READ; i++) begin
            read_bytes[idx][i] = `AUX_DATA_W'($urandom);
        end
    endtask

    task automatic build_table();
        // replies listed last attempt first
        set_row(0, by_spm, 1'b1, 1, 1'b0, {4{ack_c}}, 1, dp_aux_pkg::status_ack);
        set_row(1, by_lpm, 1'b0, 4, 1'b0, {4{ack_c}}, 1, dp_aux_pkg::status_ack);
        set_row(2, by_lpm, 1'b0, 16, 1'b0, {4{ack_c}}, 1, dp_aux_pkg::status_ack);
        set_row(3, by_spm, 1'b0, 1, 1'b0, {4{nack_c}}, 1, dp_aux_pkg::status_nack);
        set_row(4, by_spm, 1'b1, 1, 1'b0, {ack_c, ack_c, defer_c, defer_c}, 3,
                dp_aux_pkg::status_ack);
        set_row(5, by_lpm, 1'b0, 3, 1'b1, {4{ack_c}}, n_fail_req,
                dp_aux_pkg::status_failed);
        set_row(6, by_spm, 1'b1, 1, 1'b0, {4{defer_c}}, n_fail_req,
                dp_aux_pkg::status_failed);
        set_row(7, by_both, 1'b1, 1, 1'b0, {4{ack_c}}, 2, dp_aux_pkg::status_ack);
    endtask

    task automatic run_row(input int r);
        logic [`AUX_DATA_W-1:0] data_seen [$];
        row_t                   lpm_row;
        req_bytes_t             exp_req;
        req_bytes_t             exp_lpm;
        int                     exp_n;
        int                     n_data;
        logic                   spm_open;
        logic                   lpm_open;
        logic                   got_spm;
        logic                   got_lpm;
        cur_row  = r;
        row_base = req_log.size();
        spm_open = (rows[r].who != by_lpm);
        lpm_open = (rows[r].who != by_spm);
        lpm_row  = rows[r];
        // lpm carries other fields when both ask, so the two requests differ
        if (rows[r].who == by_both) begin
            lpm_row.adr = ~rows[r].adr;
            lpm_row.dat = ~rows[r].dat;
        end
        n_data   = 0;
        if (!rows[r].we && rows[r].status == dp_aux_pkg::status_ack) begin
            n_data = int'(rows[r].len);
        end
        @(posedge clk);
        if (spm_open) begin
            spm_cyc   <= 1'b1;
            spm_stb   <= 1'b1;
            spm_we    <= rows[r].we;
            spm_adr   <= rows[r].adr;
            spm_len   <= rows[r].len;
            spm_dat_w <= rows[r].dat;
        end
        if (lpm_open) begin
            lpm_cyc   <= 1'b1;
            lpm_stb   <= 1'b1;
            lpm_we    <= lpm_row.we;
            lpm_adr   <= lpm_row.adr;
            lpm_len   <= lpm_row.len;
            lpm_dat_w <= lpm_row.dat;
        end
        while (spm_open || lpm_open) begin
            @(negedge clk);
            if (reply_data_vld) begin
                if (data_seen.size() >= n_data) begin
                    stop_run($sformatf("row %0d gave more read data than requested", r));
                end
                check_byte(reply_data, read_bytes[r][data_seen.size()],
                           $sformatf("row %0d read byte %0d", r, data_seen.size()));
                data_seen.push_back(reply_data);
            end
            got_spm = spm_ack;
            got_lpm = lpm_ack;
            if (got_spm || got_lpm) begin
                if (got_spm && !spm_open) begin
                    stop_run($sformatf("row %0d: spm_ack without an SPM request", r));
                end
                if (got_lpm && !lpm_open) begin
                    stop_run($sformatf("row %0d: lpm_ack without an LPM request", r));
                end
                // spm has priority when both ask together
                if (got_lpm && spm_open) begin
                    stop_run($sformatf("row %0d: LPM acknowledged before SPM", r));
                end
                check_status(reply_status, rows[r].status, $sformatf("row %0d", r));
                if (data_seen.size() != n_data) begin
                    stop_run($sformatf("Fail %0t: row %0d got %0d read bytes, expected %0d",
                                       $time, r, data_seen.size(), n_data));
                end
                @(posedge clk);
                if (got_spm) begin
                    spm_cyc  <= 1'b0;
                    spm_stb  <= 1'b0;
                    spm_open = 1'b0;
                end else begin
                    lpm_cyc  <= 1'b0;
                    lpm_stb  <= 1'b0;
                    lpm_open = 1'b0;
                end
            end
        end
        if (req_log.size() - row_base != rows[r].n_req) begin
            stop_run($sformatf("Fail %0t: row %0d sent %0d requests, expected %0d",
                               $time, r, req_log.size() - row_base, rows[r].n_req));
        end
        exp_req = expected_request(rows[r]);
        exp_lpm = expected_request(lpm_row);
        exp_n   = rows[r].we ? 5 : 4;
        for (int i = row_base; i < req_log.size(); i++) begin
            // the later request of a shared row belongs to lpm
            if (rows[r].who == by_both && i > row_base) begin
                check_request(req_log[i], req_n_log[i], exp_lpm, exp_n, i - row_base);
            end else begin
                check_request(req_log[i], req_n_log[i], exp_req, exp_n, i - row_base);
            end
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin : main_sequence
        void'($urandom(36897));
        reset     = 1'b1;
        spm_cyc   = 1'b0;
        spm_stb   = 1'b0;
        spm_we    = 1'b0;
        spm_adr   = '0;
        spm_len   = '0;
        spm_dat_w = '0;
        lpm_cyc   = 1'b0;
        lpm_stb   = 1'b0;
        lpm_we    = 1'b0;
        lpm_adr   = '0;
        lpm_len   = '0;
        lpm_dat_w = '0;
        cur_row   = 0;
        row_base  = 0;
        build_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== dp_aux_source.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module dp_aux_source (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spm_cyc,
    input  logic                    spm_stb,
    input  logic                    spm_we,
    input  logic [`AUX_ADDR_W-1:0]  spm_adr,
    input  logic [`AUX_LEN_W-1:0]   spm_len,
    input  logic [`AUX_DATA_W-1:0]  spm_dat_w,
    output logic                    spm_ack,
    input  logic                    lpm_cyc,
    input  logic                    lpm_stb,
    input  logic                    lpm_we,
    input  logic [`AUX_ADDR_W-1:0]  lpm_adr,
    input  logic [`AUX_LEN_W-1:0]   lpm_len,
    input  logic [`AUX_DATA_W-1:0]  lpm_dat_w,
    output logic                    lpm_ack,
    output dp_aux_pkg::aux_status_t reply_status,
    output logic [`AUX_DATA_W-1:0]  reply_data,
    output logic                    reply_data_vld,
    output logic [`AUX_DATA_W-1:0]  aux_out,
    output logic                    aux_out_en,
    input  logic [`AUX_DATA_W-1:0]  aux_in,
    input  logic                    phy_start_stop
);

    aux_req_if  req_bus ();
    aux_byte_if tx_bus ();
    aux_byte_if rx_bus ();

    logic                  reply_timeout;
    dp_aux_pkg::aux_done_t done;

    ////////////////////////////////////////////////////////////////////////////
    // arbiter -> encoder -> line driver -> decoder, done back to arbiter
    ////////////////////////////////////////////////////////////////////////////

    aux_request_arbiter arbiter_inst (
        .clk          (clk),
        .reset        (reset),
        .spm_cyc      (spm_cyc),
        .spm_stb      (spm_stb),
        .spm_we       (spm_we),
        .spm_adr      (spm_adr),
        .spm_len      (spm_len),
        .spm_dat_w    (spm_dat_w),
        .spm_ack      (spm_ack),
        .lpm_cyc      (lpm_cyc),
        .lpm_stb      (lpm_stb),
        .lpm_we       (lpm_we),
        .lpm_adr      (lpm_adr),
        .lpm_len      (lpm_len),
        .lpm_dat_w    (lpm_dat_w),
        .lpm_ack      (lpm_ack),
        .reply_status (reply_status),
        .req          (req_bus.master),
        .done         (done)
    );

    native_message_encoder encoder_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req_bus.slave),
        .tx    (tx_bus.source)
    );

    aux_line_driver line_driver_inst (
        .clk            (clk),
        .reset          (reset),
        .tx             (tx_bus.sink),
        .aux_out        (aux_out),
        .aux_out_en     (aux_out_en),
        .aux_in         (aux_in),
        .phy_start_stop (phy_start_stop),
        .rx             (rx_bus.source),
        .reply_timeout  (reply_timeout)
    );

    reply_decoder decoder_inst (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx_bus.sink),
        .reply_timeout  (reply_timeout),
        .reply_data     (reply_data),
        .reply_data_vld (reply_data_vld),
        .done           (done)
    );

endmodule

// ==== reply_decoder.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module reply_decoder (
    input  logic                   clk,
    input  logic                   reset,
    aux_byte_if.sink               rx,
    input  logic                   reply_timeout,
    output logic [`AUX_DATA_W-1:0] reply_data,
    output logic                   reply_data_vld,
    output dp_aux_pkg::aux_done_t  done
);

    logic                   expect_code;
    logic                   take;
    dp_aux_pkg::aux_reply_t code_q;
    dp_aux_pkg::aux_reply_t code_now;

    // never stalls
    assign rx.ready = 1'b1;
    assign take     = rx.valid & rx.ready;

    // a one-byte reply brings its code and last together
    assign code_now = expect_code ? dp_aux_pkg::aux_reply_t'(rx.data[5:4]) : code_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            expect_code    <= 1'b1;
            reply_data_vld <= 1'b0;
            done           <= '0;
        end else begin
            reply_data_vld <= take & ~expect_code;
            done.valid     <= 1'b0;
            if (take) begin
                expect_code <= rx.last;
                if (rx.last) begin
                    done.valid   <= 1'b1;
                    done.reply   <= code_now;
                    done.timeout <= 1'b0;
                end
            end else if (reply_timeout) begin
                expect_code  <= 1'b1;
                done.valid   <= 1'b1;
                done.reply   <= dp_aux_pkg::reply_defer;
                done.timeout <= 1'b1;
            end
        end
    end

    // code byte vs read data bytes
    always_ff @(posedge clk) begin
        if (take && expect_code) begin
            code_q <= dp_aux_pkg::aux_reply_t'(rx.data[5:4]);
        end
        if (take && !expect_code) begin
            reply_data <= rx.data;
        end
    end

endmodule

// ==== aux_line_driver.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module aux_line_driver (
    input  logic                   clk,
    input  logic                   reset,
    aux_byte_if.sink               tx,
    output logic [`AUX_DATA_W-1:0] aux_out,
    output logic                   aux_out_en,
    input  logic [`AUX_DATA_W-1:0] aux_in,
    input  logic                   phy_start_stop,
    aux_byte_if.source             rx,
    output logic                   reply_timeout
);

    localparam int tmr_w = $clog2(`AUX_REPLY_TIMEOUT + 1);
    localparam logic [tmr_w-1:0] tmr_limit = `AUX_REPLY_TIMEOUT;

    typedef enum logic [1:0] {st_send, st_wait, st_recv} drv_state_t;

    drv_state_t             state;
    logic [tmr_w-1:0]       tmr;
    logic                   listen;
    logic                   in_vld_q;
    logic [`AUX_DATA_W-1:0] in_q;

    ////////////////////////////////////////////////////////////////////////////
    // request side, bytes go straight to the PHY
    ////////////////////////////////////////////////////////////////////////////

    assign tx.ready   = (state == st_send);
    assign aux_out    = tx.data;
    assign aux_out_en = tx.valid & tx.ready;

    assign listen        = (state == st_wait) | (state == st_recv);
    assign reply_timeout = (state == st_wait) & ~phy_start_stop & (tmr == tmr_limit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_send;
            tmr   <= '0;
        end else begin
            case (state)
                st_send: begin
                    if (aux_out_en && tx.last) begin
                        state <= st_wait;
                        tmr   <= tmr_w'(1);
                    end
                end
                st_wait: begin
                    if (phy_start_stop) begin
                        state <= st_recv;
                    end else if (reply_timeout) begin
                        state <= st_send;
                    end else begin
                        tmr <= tmr + 1'b1;
                    end
                end
                // reply over when the sink drops start/stop
                st_recv: begin
                    if (!phy_start_stop) begin
                        state <= st_send;
                    end
                end
                default: state <= st_send;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reply side, one stage so the fall can mark the final byte
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            in_vld_q <= 1'b0;
        end else if (rx.ready || !in_vld_q) begin
            in_vld_q <= listen & phy_start_stop;
        end
    end

    always_ff @(posedge clk) begin
        if (rx.ready || !in_vld_q) begin
            in_q <= aux_in;
        end
    end

    assign rx.valid = in_vld_q;
    assign rx.data  = in_q;
    assign rx.last  = in_vld_q & ~phy_start_stop;

endmodule

// ==== native_message_encoder.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module native_message_encoder (
    input  logic       clk,
    input  logic       reset,
    aux_req_if.slave   req,
    aux_byte_if.source tx
);

    logic                   busy;
    logic [2:0]             idx;
    logic                   is_write;
    logic                   accept;
    logic                   byte_done;
    logic                   final_byte;
    dp_aux_pkg::aux_cmd_t   cmd_q;
    logic [`AUX_ADDR_W-1:0] addr_q;
    logic [`AUX_LEN_W-1:0]  len_q;
    logic [`AUX_DATA_W-1:0] data_q;

    assign byte_done  = tx.valid & tx.ready;
    // four header bytes, a write adds its data byte
    assign final_byte = is_write ? (idx == 3'd4) : (idx == 3'd3);

    // header registers free, or the last byte leaves this cycle
    assign accept  = req.cyc & req.stb & (~busy | (byte_done & final_byte));
    assign req.ack = accept;

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q    <= req.cmd;
            addr_q   <= req.address;
            len_q    <= req.len;
            data_q   <= req.data;
            is_write <= (req.cmd == dp_aux_pkg::cmd_write);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (byte_done) begin
            if (final_byte) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // byte select
    always_comb begin
        case (idx)
            3'd0:    tx.data = {cmd_q, addr_q[`AUX_ADDR_W-1:16]};
            3'd1:    tx.data = addr_q[15:8];
            3'd2:    tx.data = addr_q[7:0];
            3'd3:    tx.data = len_q - 1'b1;
            default: tx.data = data_q;
        endcase
    end

    assign tx.valid = busy;
    assign tx.last  = busy & final_byte;

endmodule

// ==== aux_request_arbiter.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

module aux_request_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spm_cyc,
    input  logic                    spm_stb,
    input  logic                    spm_we,
    input  logic [`AUX_ADDR_W-1:0]  spm_adr,
    input  logic [`AUX_LEN_W-1:0]   spm_len,
    input  logic [`AUX_DATA_W-1:0]  spm_dat_w,
    output logic                    spm_ack,
    input  logic                    lpm_cyc,
    input  logic                    lpm_stb,
    input  logic                    lpm_we,
    input  logic [`AUX_ADDR_W-1:0]  lpm_adr,
    input  logic [`AUX_LEN_W-1:0]   lpm_len,
    input  logic [`AUX_DATA_W-1:0]  lpm_dat_w,
    output logic                    lpm_ack,
    output dp_aux_pkg::aux_status_t reply_status,
    aux_req_if.master               req,
    input  dp_aux_pkg::aux_done_t   done
);

    localparam int retry_w = $clog2(`AUX_MAX_RETRY + 1);
    localparam logic [retry_w-1:0]    retry_max = `AUX_MAX_RETRY;
    localparam logic [`AUX_LEN_W-1:0] len_one = 1;
    localparam logic [`AUX_LEN_W-1:0] len_max = `AUX_MAX_READ;

    typedef enum logic [1:0] {st_idle, st_issue, st_wait, st_respond} arb_state_t;

    arb_state_t             state;
    logic                   grant_lpm;
    logic [retry_w-1:0]     retry_cnt;
    logic                   spm_req;
    logic                   lpm_req;
    logic                   sel_we;
    logic [`AUX_ADDR_W-1:0] sel_adr;
    logic [`AUX_LEN_W-1:0]  sel_len;
    logic [`AUX_DATA_W-1:0] sel_dat;
    logic                   hold_we;
    logic [`AUX_ADDR_W-1:0] hold_adr;
    logic [`AUX_LEN_W-1:0]  hold_len;
    logic [`AUX_DATA_W-1:0] hold_dat;

    assign spm_req = spm_cyc & spm_stb;
    assign lpm_req = lpm_cyc & lpm_stb;

    // fixed priority, spm first
    always_comb begin
        if (spm_req) begin
            sel_we  = spm_we;
            sel_adr = spm_adr;
            sel_len = spm_len;
            sel_dat = spm_dat_w;
        end else begin
            sel_we  = lpm_we;
            sel_adr = lpm_adr;
            sel_len = lpm_len;
            sel_dat = lpm_dat_w;
        end
    end

    // granted request kept for every retry
    always_ff @(posedge clk) begin
        if (state == st_idle && (spm_req || lpm_req)) begin
            hold_we  <= sel_we;
            hold_adr <= sel_adr;
            hold_dat <= sel_dat;
            // a write is always one byte, reads are clamped to 1..max
            if (sel_we || sel_len == '0) begin
                hold_len <= len_one;
            end else if (sel_len > len_max) begin
                hold_len <= len_max;
            end else begin
                hold_len <= sel_len;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // attempt and retry control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            grant_lpm    <= 1'b0;
            retry_cnt    <= '0;
            reply_status <= dp_aux_pkg::status_ack;
        end else begin
            case (state)
                st_idle: begin
                    if (spm_req || lpm_req) begin
                        grant_lpm <= ~spm_req;
                        retry_cnt <= '0;
                        state     <= st_issue;
                    end
                end
                st_issue: begin
                    if (req.ack) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (done.valid) begin
                        if (done.timeout || done.reply == dp_aux_pkg::reply_defer) begin
                            if (retry_cnt == retry_max) begin
                                reply_status <= dp_aux_pkg::status_failed;
                                state        <= st_respond;
                            end else begin
                                retry_cnt <= retry_cnt + 1'b1;
                                state     <= st_issue;
                            end
                        end else if (done.reply == dp_aux_pkg::reply_ack) begin
                            reply_status <= dp_aux_pkg::status_ack;
                            state        <= st_respond;
                        end else begin
                            reply_status <= dp_aux_pkg::status_nack;
                            state        <= st_respond;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign req.cyc     = (state == st_issue);
    assign req.stb     = (state == st_issue);
    assign req.cmd     = hold_we ? dp_aux_pkg::cmd_write : dp_aux_pkg::cmd_read;
    assign req.address = hold_adr;
    assign req.len     = hold_len;
    assign req.data    = hold_dat;

    // one cycle ack, same cycle as reply_status
    assign spm_ack = (state == st_respond) & ~grant_lpm;
    assign lpm_ack = (state == st_respond) & grant_lpm;

endmodule

// ==== aux_if.sv ====
`timescale 1ns/100ps
`include "dp_aux_settings.svh"

// wishbone classic request, arbiter to encoder
interface aux_req_if;
    logic                   cyc;
    logic                   stb;
    logic                   ack;
    dp_aux_pkg::aux_cmd_t   cmd;
    logic [`AUX_ADDR_W-1:0] address;
    logic [`AUX_LEN_W-1:0]  len;
    logic [`AUX_DATA_W-1:0] data;

    modport master (
        output cyc, stb, cmd, address, len, data,
        input  ack
    );

    modport slave (
        input  cyc, stb, cmd, address, len, data,
        output ack
    );
endinterface

// byte stream, a byte moves when valid and ready are both high
interface aux_byte_if;
    logic                   valid;
    logic [`AUX_DATA_W-1:0] data;
    logic                   last;
    logic                   ready;

    modport source (
        output valid, data, last,
        input  ready
    );

    modport sink (
        input  valid, data, last,
        output ready
    );
endinterface

// ==== dp_aux_pkg.sv ====
package dp_aux_pkg;

    // native request code, upper nibble of header byte 0
    typedef enum logic [3:0] {
        cmd_write = 4'b1000,
        cmd_read  = 4'b1001
    } aux_cmd_t;

    // bits 5:4 of the first reply byte
    typedef enum logic [1:0] {
        reply_ack   = 2'b00,
        reply_nack  = 2'b01,
        reply_defer = 2'b10
    } aux_reply_t;

    // result handed back to the requester with ack
    typedef enum logic [1:0] {
        status_ack    = 2'b00,
        status_nack   = 2'b01,
        status_failed = 2'b10
    } aux_status_t;

    // one per attempt, decoder back to arbiter
    typedef struct packed {
        logic       valid;
        aux_reply_t reply;
        logic       timeout;
    } aux_done_t;

endpackage

// ==== dp_aux_settings.svh ====
`ifndef DP_AUX_SETTINGS_SVH
`define DP_AUX_SETTINGS_SVH

// DPCD address, byte and length field widths
`define AUX_ADDR_W 20
`define AUX_DATA_W 8
`define AUX_LEN_W 8

// largest read length in one native request
`define AUX_MAX_READ 16

// cycles from the last request byte until the reply is given up
`define AUX_REPLY_TIMEOUT 64

// retries after the first attempt
`define AUX_MAX_RETRY 3

`endif
